//--- common/cache_macros.svh
/* Shared cache size macros */

`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Address width, also used as the tag width
`define TAG_WIDTH 8

// Width of one cached data word
`define DATA_WIDTH 32

// Entries in the tag directory and line store
`define DIR_DEPTH 8

// Bits needed to name one directory entry
`define INDEX_WIDTH 3

`endif

//--- common/cache_pkg.sv
/* Shared cache types */

`include "cache_macros.svh"

package cache_pkg;

  // Tag taken straight from the request address
  typedef logic [`TAG_WIDTH-1:0] tag_t;

  // One data word from the backing memory
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // Slot number in the directory and line store
  typedef logic [`INDEX_WIDTH-1:0] index_t;

  // Client id, 0 is A and 1 is B
  typedef logic client_t;

  // Lookup controller FSM states
  typedef enum logic [2:0] {
    IDLE,
    SEARCH,
    EVICT,
    FETCH,
    ALLOCATE,
    FILL,
    RESPOND
  } lookup_state_t;

endpackage

//--- cache/tag_directory.sv
/* Fully associative tag directory */

`timescale 1ns/1ps

module tag_directory #(
  parameter WIDTH       = 8,
  parameter DEPTH       = 16,
  parameter INDEX_WIDTH = $clog2(DEPTH)
) (
  input  logic                   clock,
  input  logic                   resetn,
  output logic                   full,
  // Allocation port
  input  logic                   allocate_enable,
  input  logic [WIDTH-1:0]       allocate_tag,
  // Search port
  input  logic [WIDTH-1:0]       search_tag,
  output logic [INDEX_WIDTH-1:0] search_index,
  output logic                   search_hit,
  // Eviction port
  input  logic                   evict_enable,
  input  logic [INDEX_WIDTH-1:0] evict_index
);

  // Stored tags and their valid bits
  logic [WIDTH-1:0] tags [0:DEPTH-1];
  logic [DEPTH-1:0] valid;
  logic [DEPTH-1:0] valid_next;

  // Lowest free slot
  logic [INDEX_WIDTH-1:0] first_free;

  // Allocation goes through only with room left
  logic do_allocate;

  assign do_allocate = allocate_enable && !full;

  // Scan downwards so the lowest free slot wins
  always_comb begin
    first_free = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        first_free = INDEX_WIDTH'(i);
      end
    end
  end

  // Valid bits after this edge
  always_comb begin
    valid_next = valid;
    if (do_allocate) begin
      valid_next[first_free] = 1'b1;
    end
    // Eviction just drops the valid bit
    if (evict_enable) begin
      valid_next[evict_index] = 1'b0;
    end
  end

  // Lowest valid matching slot, again by a downward scan
  always_comb begin
    search_index = '0;
    search_hit   = 1'b0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (valid[i] && tags[i] == search_tag) begin
        search_index = INDEX_WIDTH'(i);
        search_hit   = 1'b1;
      end
    end
  end

  // Valid bits and full flag
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      valid <= '0;
      full  <= 1'b0;
    end else begin
      valid <= valid_next;
      // Reflects contents after this edge
      full  <= &valid_next;
    end
  end

  // Tag storage
  always_ff @(posedge clock) begin
    if (do_allocate) begin
      tags[first_free] <= allocate_tag;
    end
  end

  // Controller must evict before allocating into a full directory
  allocate_not_full: assert property (
    @(posedge clock) disable iff (!resetn)
    allocate_enable |-> !full
  ) else $error("allocation while directory full");

endmodule

//--- cache/lookup_controller.sv
/* Cache lookup controller */

`timescale 1ns/1ps

`include "cache_macros.svh"

module lookup_controller (
  input  logic               clock,
  input  logic               resetn,
  // Granted request from the arbiter
  input  logic               start,
  input  cache_pkg::client_t grant_client,
  input  cache_pkg::tag_t    grant_address,
  output logic               finish,
  // Client responses
  output logic               a_done,
  output logic               b_done,
  output cache_pkg::data_t   a_data,
  output cache_pkg::data_t   b_data,
  // Tag directory
  output logic               allocate_enable,
  output cache_pkg::tag_t    allocate_tag,
  output cache_pkg::tag_t    search_tag,
  input  logic               search_hit,
  input  cache_pkg::index_t  search_index,
  input  logic               full,
  output logic               evict_enable,
  output cache_pkg::index_t  evict_index,
  // Backing memory
  output logic               mem_read,
  output cache_pkg::tag_t    mem_address,
  input  logic               mem_ready,
  input  cache_pkg::data_t   mem_data
);

  import cache_pkg::*;

  lookup_state_t state;
  lookup_state_t state_next;

  // Next slot to evict, oldest entry first
  index_t victim;

  // One data word per directory slot
  data_t line_store [0:`DIR_DEPTH-1];

  // Word handed back to the client
  data_t response_data;

  // Miss that has to go to memory
  logic miss;

  // Read strobe goes out when entering FETCH
  logic issue_read;

  assign miss       = (state == SEARCH) && !search_hit;
  assign issue_read = (miss && !full) || (state == EVICT);

  // FSM next state
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (start) begin
          state_next = SEARCH;
        end
      end
      SEARCH: begin
        if (search_hit) begin
          state_next = RESPOND;
        end else if (full) begin
          state_next = EVICT;
        end else begin
          state_next = FETCH;
        end
      end
      EVICT: state_next = FETCH;
      FETCH: begin
        // Wait as long as the memory needs
        if (mem_ready) begin
          state_next = ALLOCATE;
        end
      end
      ALLOCATE: state_next = FILL;
      FILL: state_next = RESPOND;
      RESPOND: state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // State, victim pointer and read strobe
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      state    <= IDLE;
      victim   <= '0;
      mem_read <= 1'b0;
    end else begin
      state    <= state_next;
      mem_read <= issue_read;
      // Freed slot is refilled next, so the pointer stays FIFO
      if (state == EVICT) begin
        victim <= victim + 1'b1;
      end
    end
  end

  // Response word and line store
  always_ff @(posedge clock) begin
    if (state == SEARCH && search_hit) begin
      response_data <= line_store[search_index];
    end
    if (state == FETCH && mem_ready) begin
      response_data <= mem_data;
    end
    // New tag's slot is only known after allocation
    if (state == FILL) begin
      line_store[search_index] <= response_data;
    end
  end

  // Directory side, the granted address is the tag throughout
  assign search_tag      = grant_address;
  assign allocate_tag    = grant_address;
  assign allocate_enable = (state == ALLOCATE);
  assign evict_enable    = (state == EVICT);
  assign evict_index     = victim;

  // Memory side
  assign mem_address = grant_address;

  // Done pulse goes to the granted client only
  assign finish = (state == RESPOND);
  assign a_done = finish && (grant_client == 1'b0);
  assign b_done = finish && (grant_client == 1'b1);
  assign a_data = response_data;
  assign b_data = response_data;

  // Memory answers only the outstanding read
  ready_in_fetch: assert property (
    @(posedge clock) disable iff (!resetn)
    mem_ready |-> state == FETCH
  ) else $error("mem_ready outside FETCH");

  // Tag allocated last cycle must be found
  hit_in_fill: assert property (
    @(posedge clock) disable iff (!resetn)
    state == FILL |-> search_hit
  ) else $error("allocated tag not found in FILL");

endmodule

//--- verilog/request_arbiter.sv
/* Round-robin request arbiter */

`timescale 1ns/1ps

module request_arbiter (
  input  logic               clock,
  input  logic               resetn,
  // Client A
  input  logic               a_request,
  input  cache_pkg::tag_t    a_address,
  // Client B
  input  logic               b_request,
  input  cache_pkg::tag_t    b_address,
  // Lookup controller
  output logic               start,
  output cache_pkg::client_t grant_client,
  output cache_pkg::tag_t    grant_address,
  input  logic               finish
);

  import cache_pkg::*;

  // Transaction in flight
  logic busy;

  // Client granted most recently, B after reset so A goes first
  client_t last_served;

  // Client chosen this cycle
  client_t pick;

  // Something to grant this cycle
  logic take;

  // B wins when alone or when A was served last
  assign pick = b_request && (!a_request || last_served == 1'b0);
  assign take = !busy && (a_request || b_request);

  // Grant stays on the client served last
  assign grant_client = last_served;

  // Control state
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      busy        <= 1'b0;
      start       <= 1'b0;
      last_served <= 1'b1;
    end else begin
      start <= take;
      if (take) begin
        busy        <= 1'b1;
        last_served <= pick;
      end else if (finish) begin
        // Free again, sampling resumes next cycle
        busy <= 1'b0;
      end
    end
  end

  // Address of the granted client, held for the transaction
  always_ff @(posedge clock) begin
    if (take) begin
      grant_address <= pick ? b_address : a_address;
    end
  end

  // No new start until the controller has finished
  one_transaction: assert property (
    @(posedge clock) disable iff (!resetn)
    start |=> !start until_with finish
  ) else $error("start while transaction busy");

endmodule

//--- verilog/shared_cache_top.sv
/* Shared lookup cache top level */

`timescale 1ns/1ps

`include "cache_macros.svh"

module shared_cache_top (
  input  logic             clock,
  input  logic             resetn,
  // Client A
  input  logic             a_request,
  input  cache_pkg::tag_t  a_address,
  output logic             a_done,
  output cache_pkg::data_t a_data,
  // Client B
  input  logic             b_request,
  input  cache_pkg::tag_t  b_address,
  output logic             b_done,
  output cache_pkg::data_t b_data,
  // Backing memory
  output logic             mem_read,
  output cache_pkg::tag_t  mem_address,
  input  logic             mem_ready,
  input  cache_pkg::data_t mem_data
);

  import cache_pkg::*;

  // Arbiter to controller
  logic    start;
  logic    finish;
  client_t grant_client;
  tag_t    grant_address;

  // Controller to directory
  logic    allocate_enable;
  tag_t    allocate_tag;
  tag_t    search_tag;
  logic    search_hit;
  index_t  search_index;
  logic    full;
  logic    evict_enable;
  index_t  evict_index;

  request_arbiter u_arbiter (
    .clock         (clock),
    .resetn        (resetn),
    .a_request     (a_request),
    .a_address     (a_address),
    .b_request     (b_request),
    .b_address     (b_address),
    .start         (start),
    .grant_client  (grant_client),
    .grant_address (grant_address),
    .finish        (finish)
  );

  lookup_controller u_controller (
    .clock           (clock),
    .resetn          (resetn),
    .start           (start),
    .grant_client    (grant_client),
    .grant_address   (grant_address),
    .finish          (finish),
    .a_done          (a_done),
    .b_done          (b_done),
    .a_data          (a_data),
    .b_data          (b_data),
    .allocate_enable (allocate_enable),
    .allocate_tag    (allocate_tag),
    .search_tag      (search_tag),
    .search_hit      (search_hit),
    .search_index    (search_index),
    .full            (full),
    .evict_enable    (evict_enable),
    .evict_index     (evict_index),
    .mem_read        (mem_read),
    .mem_address     (mem_address),
    .mem_ready       (mem_ready),
    .mem_data        (mem_data)
  );

  // Directory sized from the shared macros
  tag_directory #(
    .WIDTH       (`TAG_WIDTH),
    .DEPTH       (`DIR_DEPTH),
    .INDEX_WIDTH (`INDEX_WIDTH)
  ) u_directory (
    .clock           (clock),
    .resetn          (resetn),
    .full            (full),
    .allocate_enable (allocate_enable),
    .allocate_tag    (allocate_tag),
    .search_tag      (search_tag),
    .search_index    (search_index),
    .search_hit      (search_hit),
    .evict_enable    (evict_enable),
    .evict_index     (evict_index)
  );

endmodule

//--- test/shared_cache_checker.sv
/* Shared cache response checker */

`timescale 1ns/1ps

`include "cache_macros.svh"

module shared_cache_checker #(
  parameter logic [31:0] WORD_SCALE        = 32'h1,
  parameter logic [31:0] WORD_MASK         = 32'h0,
  parameter int          TRANSACTION_LIMIT = 200
) (
  input  logic             clock,
  input  logic             resetn,
  input  logic             a_request,
  input  cache_pkg::tag_t  a_address,
  input  logic             a_done,
  input  cache_pkg::data_t a_data,
  input  logic             b_request,
  input  cache_pkg::tag_t  b_address,
  input  logic             b_done,
  input  cache_pkg::data_t b_data,
  input  logic             mem_read,
  input  cache_pkg::tag_t  mem_address,
  output int               error_count,
  output int               check_count
);

  import cache_pkg::*;

  // Grant, search, respond
  localparam int HIT_CYCLES = 3;

  int errors = 0;
  int checks = 0;

  // Arbiter model, B counts as served last after reset
  logic    busy;
  client_t last_served;
  client_t grant;
  tag_t    grant_tag;

  // Transaction in flight
  logic  expect_miss;
  int    read_count;
  int    cycle_count;
  data_t response;

  // Directory model, oldest tag at the front
  tag_t fifo_model [$];

  assign error_count = errors;
  assign check_count = checks;

  // Word the backing memory holds for an address
  function automatic data_t expected_word(input tag_t address);
    return (data_t'(address) * WORD_SCALE) ^ WORD_MASK;
  endfunction

  function automatic logic model_holds(input tag_t address);
    foreach (fifo_model[i]) begin
      if (fifo_model[i] == address) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic report_problem(input string text);
    errors++;
    $display("Error at %0t ns: %s", $time, text);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
    end
  endtask

  // Sample everything at the rising edge, before the DUT updates
  always @(posedge clock) begin
    if (!resetn) begin
      // Quiet outputs while in reset
      check_value("a_done", a_done, 1'b0);
      check_value("b_done", b_done, 1'b0);
      check_value("mem_read", mem_read, 1'b0);
      busy        = 1'b0;
      last_served = 1'b1;
      fifo_model.delete();
    end else begin
      if (a_done && b_done) begin
        report_problem("a_done and b_done pulsed in the same cycle");
      end
      // One read per miss, for the granted tag
      if (mem_read) begin
        if (!busy || !expect_miss || read_count != 0) begin
          report_problem($sformatf("unexpected memory read for address 0x%h", mem_address));
        end else begin
          check_value("mem_address", mem_address, grant_tag);
        end
        read_count++;
      end
      if (busy) begin
        cycle_count++;
        if (a_done || b_done) begin
          check_value("a_done", a_done, grant == 1'b0);
          check_value("b_done", b_done, grant == 1'b1);
          response = grant ? b_data : a_data;
          check_value(grant ? "b_data" : "a_data", response, expected_word(grant_tag));
          if (expect_miss && read_count == 0) begin
            report_problem($sformatf("miss on 0x%h finished without a memory read", grant_tag));
          end
          if (!expect_miss && cycle_count != HIT_CYCLES) begin
            report_problem($sformatf("hit on 0x%h took %0d cycles instead of %0d",
                                     grant_tag, cycle_count, HIT_CYCLES));
          end
          // Arbiter frees up here and samples next cycle
          busy = 1'b0;
        end else if (cycle_count > TRANSACTION_LIMIT) begin
          report_problem($sformatf("no done pulse for address 0x%h within %0d cycles",
                                   grant_tag, TRANSACTION_LIMIT));
          busy = 1'b0;
        end
      end else if (a_done || b_done) begin
        report_problem("done pulse with no request granted");
      end else if (a_request || b_request) begin
        // Round robin, the client not served last wins a tie
        if (a_request && b_request) begin
          grant = ~last_served;
        end else begin
          grant = b_request;
        end
        grant_tag   = grant ? b_address : a_address;
        last_served = grant;
        expect_miss = !model_holds(grant_tag);
        if (expect_miss) begin
          // Full directory drops its oldest tag
          if (fifo_model.size() == `DIR_DEPTH) begin
            fifo_model.delete(0);
          end
          fifo_model.push_back(grant_tag);
        end
        busy        = 1'b1;
        cycle_count = 0;
        read_count  = 0;
      end
    end
  end

endmodule

//--- test/shared_cache_tb.sv
/* Shared cache testbench */

`timescale 1ns/1ps

module shared_cache_tb;

  import cache_pkg::*;

  localparam data_t WORD_SCALE  = 32'h9e3779b1;
  localparam data_t WORD_MASK   = 32'h5a5a0f0f;
  localparam int    DRAIN_LIMIT = 5000;

  logic  clock;
  logic  resetn;
  logic  a_request;
  tag_t  a_address;
  logic  a_done;
  data_t a_data;
  logic  b_request;
  tag_t  b_address;
  logic  b_done;
  data_t b_data;
  logic  mem_read;
  tag_t  mem_address;
  logic  mem_ready;
  data_t mem_data;

  int error_count;
  int check_count;
  int timeout_count;

  // Galois LFSR state
  logic [31:0] lfsr;
  logic [31:0] bits;

  // Addresses each client still has to request
  tag_t a_queue [$];
  tag_t b_queue [$];

  // Memory delay for each coming read
  int delay_queue [$];

  // Memory model
  tag_t read_address;
  int   countdown;

  shared_cache_top UUT (
    .clock       (clock),
    .resetn      (resetn),
    .a_request   (a_request),
    .a_address   (a_address),
    .a_done      (a_done),
    .a_data      (a_data),
    .b_request   (b_request),
    .b_address   (b_address),
    .b_done      (b_done),
    .b_data      (b_data),
    .mem_read    (mem_read),
    .mem_address (mem_address),
    .mem_ready   (mem_ready),
    .mem_data    (mem_data)
  );

  shared_cache_checker #(
    .WORD_SCALE (WORD_SCALE),
    .WORD_MASK  (WORD_MASK)
  ) u_checker (
    .clock       (clock),
    .resetn      (resetn),
    .a_request   (a_request),
    .a_address   (a_address),
    .a_done      (a_done),
    .a_data      (a_data),
    .b_request   (b_request),
    .b_address   (b_address),
    .b_done      (b_done),
    .b_data      (b_data),
    .mem_read    (mem_read),
    .mem_address (mem_address),
    .error_count (error_count),
    .check_count (check_count)
  );

  // 8 ns clock
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic data_t memory_word(input tag_t address);
    return (data_t'(address) * WORD_SCALE) ^ WORD_MASK;
  endfunction

  // Feedback taps at bits 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] value);
    if (value[0]) begin
      return (value >> 1) ^ 32'h80200003;
    end
    return value >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  function automatic logic clients_busy();
    return a_queue.size() > 0 || b_queue.size() > 0 || a_request || b_request;
  endfunction

  task automatic wait_until_idle(input string phase);
    int cycles;
    cycles = 0;
    while (clients_busy() && cycles < DRAIN_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (clients_busy()) begin
      timeout_count++;
      $display("Timeout: clients still busy after %0d cycles in %s", DRAIN_LIMIT, phase);
    end
  endtask

  // Client A keeps its request up while it has addresses left
  always @(posedge clock) begin
    if (!a_request || a_done) begin
      if (a_queue.size() > 0) begin
        a_request <= 1'b1;
        a_address <= a_queue.pop_front();
      end else begin
        a_request <= 1'b0;
      end
    end
  end

  // Client B behaves the same
  always @(posedge clock) begin
    if (!b_request || b_done) begin
      if (b_queue.size() > 0) begin
        b_request <= 1'b1;
        b_address <= b_queue.pop_front();
      end else begin
        b_request <= 1'b0;
      end
    end
  end

  // Backing memory answers one read at a time
  // Delay of 1 when none is queued
  always @(posedge clock) begin
    mem_ready <= 1'b0;
    if (mem_read) begin
      read_address = mem_address;
      countdown    = (delay_queue.size() > 0) ? delay_queue.pop_front() : 1;
    end else if (countdown > 0) begin
      countdown = countdown - 1;
      if (countdown == 0) begin
        mem_ready <= 1'b1;
        mem_data  <= memory_word(read_address);
      end
    end
  end

  initial begin
    resetn        = 1'b1;
    a_request     = 1'b0;
    a_address     = '0;
    b_request     = 1'b0;
    b_address     = '0;
    mem_ready     = 1'b0;
    mem_data      = '0;
    lfsr          = 32'hf335748d;
    countdown     = 0;
    timeout_count = 0;
    // Reset held over five rising edges
    #1 resetn = 1'b0;
    repeat (5) @(posedge clock);
    resetn <= 1'b1;
    @(negedge clock);

    // Both clients start together after reset so A wins the first tie
    a_queue = '{8'h10, 8'h10};
    b_queue = '{8'h10, 8'h11, 8'h11};
    wait_until_idle("miss then hit");

    // Both clients back to back so grants alternate
    a_queue = '{8'h20, 8'h10, 8'h20};
    b_queue = '{8'h30, 8'h11, 8'h30};
    wait_until_idle("arbitration");

    // Nine new tags push the first one out
    for (int i = 0; i < 9; i++) begin
      a_queue.push_back(tag_t'(8'h40 + i));
    end
    a_queue.push_back(8'h40);
    wait_until_idle("FIFO replacement");

    // Pool of 16 addresses against 8 entries
    for (int i = 0; i < 80; i++) begin
      draw_bits(4, bits);
      a_queue.push_back({4'h8, bits[3:0]});
      draw_bits(4, bits);
      b_queue.push_back({4'h8, bits[3:0]});
      draw_bits(3, bits);
      delay_queue.push_back(int'(bits[2:0]) + 1);
      draw_bits(3, bits);
      delay_queue.push_back(int'(bits[2:0]) + 1);
    end
    wait_until_idle("random mix");
    repeat (2) @(negedge clock);

    $display("Closing counts: %0d checks, %0d errors, %0d timeouts",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+common
common/cache_pkg.sv
cache/tag_directory.sv
cache/lookup_controller.sv
verilog/request_arbiter.sv
verilog/shared_cache_top.sv
test/shared_cache_checker.sv
test/shared_cache_tb.sv
